// File: design/cdb_arbiter.sv
`timescale 1ns/1ps

module cdb_arbiter (
    input  logic                                   clk_i,
    input  logic                                   rst_n_i,
    input  tomasulo_pkg::cdb_t [tomasulo_pkg::num_rs-1:0] req_i,
    output logic [tomasulo_pkg::num_rs-1:0]        grant_o,
    output tomasulo_pkg::cdb_t                     cdb_o
);
    import tomasulo_pkg::*;

    logic [rs_idw-1:0]  ptr_q;
    logic [rs_idw-1:0]  sel;
    logic [rs_idw-1:0]  idx;
    logic               found;
    logic               cdb_valid_q;
    logic [rob_idw-1:0] cdb_tag_q;
    logic [xlen-1:0]    cdb_value_q;

    // Search starts one past the last granted station
    always_comb begin
        sel     = ptr_q;
        found   = 1'b0;
        idx     = '0;
        grant_o = '0;
        for (int i = 1; i <= num_rs; i++) begin
            idx = rs_idw'((int'(ptr_q) + i) % num_rs);
            if (!found && req_i[idx].valid) begin
                found = 1'b1;
                sel   = idx;
            end
        end
        grant_o[sel] = found;
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ptr_q       <= '0;
            cdb_valid_q <= 1'b0;
        end else begin
            cdb_valid_q <= found;
            if (found) begin
                ptr_q <= sel;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (found) begin
            cdb_tag_q   <= req_i[sel].tag;
            cdb_value_q <= req_i[sel].value;
        end
    end

    assign cdb_o.valid = cdb_valid_q;
    assign cdb_o.tag   = cdb_tag_q;
    assign cdb_o.value = cdb_value_q;

endmodule

// File: design/issue_unit.sv
`timescale 1ns/1ps

module issue_unit (
    input  logic                                  clk_i,
    input  logic                                  rst_n_i,
    input  tomasulo_pkg::apb_req_t                apb_i,
    output tomasulo_pkg::apb_rsp_t                apb_o,
    input  logic                                  rob_full_i,
    input  logic [tomasulo_pkg::rob_idw-1:0]      rob_tail_i,
    output tomasulo_pkg::rob_alloc_t              rob_alloc_o,
    output logic [1:0][tomasulo_pkg::rob_idw-1:0] rob_query_tag_o,
    input  tomasulo_pkg::operand_t [1:0]          rob_query_i,
    output logic [1:0][tomasulo_pkg::reg_aw-1:0]  rf_raddr_o,
    input  logic [1:0][tomasulo_pkg::xlen-1:0]    rf_rdata_i,
    input  logic [tomasulo_pkg::num_rs-1:0]       rs_busy_i,
    output logic [tomasulo_pkg::num_rs-1:0]       rs_we_o,
    output tomasulo_pkg::rs_entry_t               rs_entry_o,
    input  tomasulo_pkg::cdb_t                    cdb_i,
    input  tomasulo_pkg::commit_t                 commit_i
);
    import tomasulo_pkg::*;

    logic                        access;
    logic                        issue_hit;
    logic                        reg_hit;
    logic [apb_aw-1:0]           reg_off;
    logic                        can_issue;
    logic                        issue;
    inst_t                       inst;
    logic [1:0][reg_aw-1:0]      src_reg;
    logic [1:0]                  src_used;
    operand_t [1:0]              src_op;
    logic [num_rs-1:0]           rs_sel;

    // Alias table
    logic [num_regs-1:0]         pend_q;
    logic [rob_idw-1:0]          tag_q [num_regs];
    // Tag of the next entry to retire, follows the ROB head
    logic [rob_idw-1:0]          commit_tag_q;

    assign access    = apb_i.psel & apb_i.penable;
    assign issue_hit = apb_i.paddr == addr_issue;
    assign reg_off   = apb_i.paddr - addr_reg_base;
    assign reg_hit   = (apb_i.paddr >= addr_reg_base)
                     && (reg_off < apb_aw'(4 * num_regs))
                     && (reg_off[1:0] == 2'b00);

    assign inst      = inst_t'(apb_i.pwdata);
    assign can_issue = !rob_full_i && (|(~rs_busy_i));
    assign issue     = access && apb_i.pwrite && issue_hit && can_issue;

    assign src_reg[0]  = inst.rs1;
    assign src_reg[1]  = inst.rs2;
    assign src_used[0] = inst.op != OP_LI;
    assign src_used[1] = (inst.op != OP_LI) && (inst.op != OP_ADDI);

    // Port 0 serves APB reads, which never coincide with an issue
    assign rf_raddr_o[0] = (access && !apb_i.pwrite) ? reg_off[2 +: reg_aw] : inst.rs1;
    assign rf_raddr_o[1] = inst.rs2;

    always_comb begin
        rs_sel = '0;
        for (int i = num_rs - 1; i >= 0; i--) begin
            if (!rs_busy_i[i]) begin
                rs_sel    = '0;
                rs_sel[i] = 1'b1;
            end
        end
    end

    // Register file, then ROB, then a same-cycle CDB broadcast
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            rob_query_tag_o[s] = tag_q[src_reg[s]];
            src_op[s].tag      = tag_q[src_reg[s]];
            src_op[s].ready    = 1'b1;
            src_op[s].value    = rf_rdata_i[s];
            if (!src_used[s]) begin
                src_op[s].value = '0;
            end else if (pend_q[src_reg[s]]) begin
                if (rob_query_i[s].ready) begin
                    src_op[s].value = rob_query_i[s].value;
                end else if (cdb_i.valid && cdb_i.tag == tag_q[src_reg[s]]) begin
                    src_op[s].value = cdb_i.value;
                end else begin
                    src_op[s].ready = 1'b0;
                end
            end
        end
    end

    always_comb begin
        apb_o = '0;
        if (access) begin
            if (apb_i.pwrite) begin
                apb_o.pready  = issue_hit ? can_issue : 1'b1;
                apb_o.pslverr = !issue_hit;
            end else begin
                apb_o.pready  = 1'b1;
                apb_o.pslverr = !reg_hit;
                apb_o.prdata  = reg_hit ? rf_rdata_i[0] : '0;
            end
        end
    end

    assign rob_alloc_o.valid = issue;
    assign rob_alloc_o.rd    = inst.rd;
    assign rs_we_o           = issue ? rs_sel : '0;
    assign rs_entry_o.op     = inst.op;
    assign rs_entry_o.dest   = rob_tail_i;
    assign rs_entry_o.src1   = src_op[0];
    assign rs_entry_o.src2   = src_op[1];
    assign rs_entry_o.imm    = inst.imm;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pend_q       <= '0;
            commit_tag_q <= '0;
        end else begin
            if (commit_i.valid) begin
                commit_tag_q <= commit_tag_q + 1'b1;
                if (tag_q[commit_i.rd] == commit_tag_q) begin
                    pend_q[commit_i.rd] <= 1'b0;
                end
            end
            // A rename in the same cycle overrides the clear
            if (issue) begin
                pend_q[inst.rd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue) begin
            tag_q[inst.rd] <= rob_tail_i;
        end
    end

endmodule

// File: design/register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic                                 clk_i,
    input  logic                                 rst_n_i,
    input  tomasulo_pkg::commit_t                commit_i,
    input  logic [1:0][tomasulo_pkg::reg_aw-1:0] raddr_i,
    output logic [1:0][tomasulo_pkg::xlen-1:0]   rdata_o
);
    import tomasulo_pkg::*;

    logic [xlen-1:0] regs_q [num_regs];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int r = 0; r < num_regs; r++) begin
                regs_q[r] <= '0;
            end
        end else if (commit_i.valid) begin
            regs_q[commit_i.rd] <= commit_i.value;
        end
    end

    // No write bypass, alias table still marks rd pending here
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            rdata_o[p] = regs_q[raddr_i[p]];
        end
    end

endmodule

// File: design/reorder_buffer.sv
`timescale 1ns/1ps

module reorder_buffer (
    input  logic                                  clk_i,
    input  logic                                  rst_n_i,
    input  tomasulo_pkg::rob_alloc_t              alloc_i,
    output logic                                  full_o,
    output logic [tomasulo_pkg::rob_idw-1:0]      tail_o,
    input  logic [1:0][tomasulo_pkg::rob_idw-1:0] query_tag_i,
    output tomasulo_pkg::operand_t [1:0]          query_o,
    input  tomasulo_pkg::cdb_t                    cdb_i,
    output tomasulo_pkg::commit_t                 commit_o
);
    import tomasulo_pkg::*;

    logic [reg_aw-1:0]    rd_q    [rob_depth];
    logic [xlen-1:0]      value_q [rob_depth];
    logic [rob_depth-1:0] ready_q;

    logic [rob_idw-1:0]   head_q;
    logic [rob_idw-1:0]   tail_q;
    logic [rob_idw:0]     count_q;
    logic                 head_done;

    logic                 commit_valid_q;
    logic [reg_aw-1:0]    commit_rd_q;
    logic [xlen-1:0]      commit_value_q;

    assign full_o    = count_q == (rob_idw + 1)'(rob_depth);
    assign tail_o    = tail_q;
    assign head_done = (count_q != '0) && ready_q[head_q];

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            query_o[s].ready = ready_q[query_tag_i[s]];
            query_o[s].tag   = query_tag_i[s];
            query_o[s].value = value_q[query_tag_i[s]];
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            head_q         <= '0;
            tail_q         <= '0;
            count_q        <= '0;
            ready_q        <= '0;
            commit_valid_q <= 1'b0;
        end else begin
            commit_valid_q <= head_done;
            if (head_done) begin
                head_q <= head_q + 1'b1;
            end
            if (alloc_i.valid) begin
                tail_q          <= tail_q + 1'b1;
                ready_q[tail_q] <= 1'b0;
            end
            // Broadcast tag is always a live entry, never the tail
            if (cdb_i.valid) begin
                ready_q[cdb_i.tag] <= 1'b1;
            end
            count_q <= count_q + (rob_idw + 1)'(alloc_i.valid)
                               - (rob_idw + 1)'(head_done);
        end
    end

    always_ff @(posedge clk_i) begin
        if (alloc_i.valid) begin
            rd_q[tail_q] <= alloc_i.rd;
        end
        if (cdb_i.valid) begin
            value_q[cdb_i.tag] <= cdb_i.value;
        end
        if (head_done) begin
            commit_rd_q    <= rd_q[head_q];
            commit_value_q <= value_q[head_q];
        end
    end

    assign commit_o.valid = commit_valid_q;
    assign commit_o.rd    = commit_rd_q;
    assign commit_o.value = commit_value_q;

endmodule

// File: design/reservation_station.sv
`timescale 1ns/1ps

module reservation_station (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    we_i,
    input  tomasulo_pkg::rs_entry_t entry_i,
    input  tomasulo_pkg::cdb_t      cdb_i,
    input  logic                    grant_i,
    output logic                    busy_o,
    output tomasulo_pkg::cdb_t      req_o
);
    import tomasulo_pkg::*;

    logic            busy_q;
    logic            req_q;
    rs_entry_t       entry_q;
    logic [xlen-1:0] result_q;
    logic [xlen-1:0] alu_res;
    logic [xlen-1:0] imm_sx;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic            ops_ready;
    logic            hit1;
    logic            hit2;

    assign a         = entry_q.src1.value;
    assign b         = entry_q.src2.value;
    assign imm_sx    = {{(xlen - imm_w){entry_q.imm[imm_w-1]}}, entry_q.imm};
    assign ops_ready = busy_q && entry_q.src1.ready && entry_q.src2.ready;

    // CDB snoop for operands still waiting on a producer
    assign hit1 = busy_q && !entry_q.src1.ready && cdb_i.valid && cdb_i.tag == entry_q.src1.tag;
    assign hit2 = busy_q && !entry_q.src2.ready && cdb_i.valid && cdb_i.tag == entry_q.src2.tag;

    always_comb begin
        case (entry_q.op)
            OP_ADD:  alu_res = a + b;
            OP_SUB:  alu_res = a - b;
            OP_AND:  alu_res = a & b;
            OP_OR:   alu_res = a | b;
            OP_XOR:  alu_res = a ^ b;
            OP_SLL:  alu_res = a << b[4:0];
            OP_ADDI: alu_res = a + imm_sx;
            OP_LI:   alu_res = imm_sx;
            default: alu_res = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
            req_q  <= 1'b0;
        end else if (we_i) begin
            busy_q <= 1'b1;
            req_q  <= 1'b0;
        end else if (grant_i) begin
            busy_q <= 1'b0;
            req_q  <= 1'b0;
        end else if (ops_ready) begin
            req_q  <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            entry_q <= entry_i;
        end else begin
            if (hit1) begin
                entry_q.src1 <= '{ready: 1'b1, tag: cdb_i.tag, value: cdb_i.value};
            end
            if (hit2) begin
                entry_q.src2 <= '{ready: 1'b1, tag: cdb_i.tag, value: cdb_i.value};
            end
        end
        // Result is held once the request is up
        if (ops_ready && !req_q) begin
            result_q <= alu_res;
        end
    end

    assign busy_o      = busy_q;
    assign req_o.valid = req_q;
    assign req_o.tag   = entry_q.dest;
    assign req_o.value = result_q;

endmodule

// File: design/tomasulo_core.sv
`timescale 1ns/1ps

module tomasulo_core (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  tomasulo_pkg::apb_req_t apb_i,
    output tomasulo_pkg::apb_rsp_t apb_o,
    output tomasulo_pkg::commit_t  commit_o
);
    import tomasulo_pkg::*;

    rob_alloc_t              rob_alloc;
    logic                    rob_full;
    logic [rob_idw-1:0]      rob_tail;
    logic [1:0][rob_idw-1:0] rob_query_tag;
    operand_t [1:0]          rob_query;
    logic [1:0][reg_aw-1:0]  rf_raddr;
    logic [1:0][xlen-1:0]    rf_rdata;
    logic [num_rs-1:0]       rs_busy;
    logic [num_rs-1:0]       rs_we;
    logic [num_rs-1:0]       rs_grant;
    rs_entry_t               rs_entry;
    cdb_t [num_rs-1:0]       rs_req;
    cdb_t                    cdb;
    commit_t                 commit;

    issue_unit issue_unit_i (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .apb_i           (apb_i),
        .apb_o           (apb_o),
        .rob_full_i      (rob_full),
        .rob_tail_i      (rob_tail),
        .rob_alloc_o     (rob_alloc),
        .rob_query_tag_o (rob_query_tag),
        .rob_query_i     (rob_query),
        .rf_raddr_o      (rf_raddr),
        .rf_rdata_i      (rf_rdata),
        .rs_busy_i       (rs_busy),
        .rs_we_o         (rs_we),
        .rs_entry_o      (rs_entry),
        .cdb_i           (cdb),
        .commit_i        (commit)
    );

    for (genvar g = 0; g < num_rs; g++) begin : g_rs
        reservation_station reservation_station_i (
            .clk_i   (clk_i),
            .rst_n_i (rst_n_i),
            .we_i    (rs_we[g]),
            .entry_i (rs_entry),
            .cdb_i   (cdb),
            .grant_i (rs_grant[g]),
            .busy_o  (rs_busy[g]),
            .req_o   (rs_req[g])
        );
    end

    cdb_arbiter cdb_arbiter_i (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .req_i   (rs_req),
        .grant_o (rs_grant),
        .cdb_o   (cdb)
    );

    reorder_buffer reorder_buffer_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .alloc_i     (rob_alloc),
        .full_o      (rob_full),
        .tail_o      (rob_tail),
        .query_tag_i (rob_query_tag),
        .query_o     (rob_query),
        .cdb_i       (cdb),
        .commit_o    (commit)
    );

    register_file register_file_i (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .commit_i (commit),
        .raddr_i  (rf_raddr),
        .rdata_o  (rf_rdata)
    );

    assign commit_o = commit;

endmodule

// File: design/tomasulo_pkg.sv
package tomasulo_pkg;

    localparam int xlen      = 32;
    localparam int num_regs  = 16;
    localparam int reg_aw    = 4;
    localparam int rob_depth = 8;
    localparam int rob_idw   = 3;
    localparam int num_rs    = 4;
    localparam int rs_idw    = $clog2(num_rs);
    localparam int imm_w     = 16;
    localparam int apb_aw    = 12;

    // APB register map
    localparam logic [apb_aw-1:0] addr_issue    = 12'h000;
    localparam logic [apb_aw-1:0] addr_reg_base = 12'h100;

    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_SLL  = 4'd5,
        OP_ADDI = 4'd6,
        OP_LI   = 4'd7
    } op_e;

    // Layout of the APB write data to the issue register
    typedef struct packed {
        op_e               op;
        logic [reg_aw-1:0] rd;
        logic [reg_aw-1:0] rs1;
        logic [reg_aw-1:0] rs2;
        logic [imm_w-1:0]  imm;
    } inst_t;

    typedef struct packed {
        logic               ready;
        logic [rob_idw-1:0] tag;
        logic [xlen-1:0]    value;
    } operand_t;

    typedef struct packed {
        op_e                op;
        logic [rob_idw-1:0] dest;
        operand_t           src1;
        operand_t           src2;
        logic [imm_w-1:0]   imm;
    } rs_entry_t;

    typedef struct packed {
        logic               valid;
        logic [rob_idw-1:0] tag;
        logic [xlen-1:0]    value;
    } cdb_t;

    typedef struct packed {
        logic              valid;
        logic [reg_aw-1:0] rd;
        logic [xlen-1:0]   value;
    } commit_t;

    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [apb_aw-1:0] paddr;
        logic [xlen-1:0]   pwdata;
    } apb_req_t;

    typedef struct packed {
        logic            pready;
        logic [xlen-1:0] prdata;
        logic            pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic              valid;
        logic [reg_aw-1:0] rd;
    } rob_alloc_t;

endpackage

// File: files.f
+incdir+sim
design/tomasulo_pkg.sv
design/issue_unit.sv
design/reservation_station.sv
design/cdb_arbiter.sv
design/reorder_buffer.sv
design/register_file.sv
design/tomasulo_core.sv
sim/tb_tomasulo_core.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, verdict taken from sim.log
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module tb_tomasulo_core -f files.f -o sim_tb; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
    exit 1
fi
if [ "$run_status" -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi
if ! grep -q "STATUS: PASS" sim.log; then
    echo "Simulation ended without a verdict"
    exit 1
fi
exit 0

// File: sim/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// In-order model, registers written at issue time
logic [xlen-1:0] model_regs [num_regs];
commit_t         exp_q [$];

task automatic clear_model();
    for (int r = 0; r < num_regs; r++) begin
        model_regs[r] = '0;
    end
    exp_q.delete();
endtask

function automatic logic [xlen-1:0] expected_value(input inst_t inst);
    logic [xlen-1:0] x;
    logic [xlen-1:0] y;
    logic [xlen-1:0] imm_ext;
    logic [xlen-1:0] res;
    x       = model_regs[inst.rs1];
    y       = model_regs[inst.rs2];
    imm_ext = {{(xlen - 16){inst.imm[15]}}, inst.imm};
    case (inst.op)
        OP_ADD:  res = x + y;
        OP_SUB:  res = x - y;
        OP_AND:  res = x & y;
        OP_OR:   res = x | y;
        OP_XOR:  res = x ^ y;
        // Shift amount is the low 5 bits of rs2
        OP_SLL:  res = x << y[4:0];
        OP_ADDI: res = x + imm_ext;
        OP_LI:   res = imm_ext;
        default: res = '0;
    endcase
    return res;
endfunction

task automatic record_issue(input inst_t inst);
    commit_t c;
    c.valid = 1'b1;
    c.rd    = inst.rd;
    c.value = expected_value(inst);
    model_regs[inst.rd] = c.value;
    exp_q.push_back(c);
endtask

task automatic check_commit(input commit_t got, input commit_t exp);
    if (got.rd !== exp.rd) begin
        abort_run($sformatf("ERROR: commit_o.rd got 0x%h expected 0x%h", got.rd, exp.rd));
    end else if (got.value !== exp.value) begin
        abort_run($sformatf("ERROR: commit_o.value got 0x%h expected 0x%h",
                            got.value, exp.value));
    end
endtask

task automatic check_word(input string name, input logic [xlen-1:0] got,
                          input logic [xlen-1:0] exp);
    if (got !== exp) begin
        abort_run($sformatf("ERROR: %s got 0x%h expected 0x%h", name, got, exp));
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        abort_run($sformatf("ERROR: %s got 0x%h expected 0x%h", name, got, exp));
    end
endtask

`endif

// File: sim/tb_tomasulo_core.sv
`timescale 1ns/1ps

module tb_tomasulo_core;
    import tomasulo_pkg::*;

    localparam int n_prog   = 200;
    localparam int n_burst  = 40;
    localparam int n_tail   = 12;
    localparam int clk_half = 10;

    logic     clk_i;
    logic     rst_n_i;
    apb_req_t apb_i;
    apb_rsp_t apb_o;
    commit_t  commit_o;

    integer   seed;
    int       cycle_cnt  = 0;
    int       issue_cnt  = 0;
    int       commit_cnt = 0;

    tomasulo_core tomasulo_core_i (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .apb_i    (apb_i),
        .apb_o    (apb_o),
        .commit_o (commit_o)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped on error");
    endtask

    `include "tb_model.svh"

    always #clk_half clk_i = ~clk_i;

    // Limit grows with the instructions issued so far
    always @(posedge clk_i) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > (issue_cnt + 16) * 40) begin
            abort_run($sformatf("Timeout after %0d cycles, %0d issued and %0d committed",
                                cycle_cnt, issue_cnt, commit_cnt));
        end
    end

    always @(negedge clk_i) begin : commit_monitor
        commit_t expected;
        if (commit_o.valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                abort_run("A commit appeared with no instruction outstanding");
            end else begin
                expected = exp_q.pop_front();
                check_commit(commit_o, expected);
                commit_cnt = commit_cnt + 1;
            end
        end
    end

    // Entered and left 1 ns after a rising edge
    task automatic apb_xfer(input logic write, input logic [apb_aw-1:0] addr,
                            input logic [xlen-1:0] wdata,
                            output logic [xlen-1:0] rdata, output logic err);
        apb_i.psel    = 1'b1;
        apb_i.penable = 1'b0;
        apb_i.pwrite  = write;
        apb_i.paddr   = addr;
        apb_i.pwdata  = wdata;
        @(posedge clk_i);
        #1;
        apb_i.penable = 1'b1;
        @(negedge clk_i);
        while (apb_o.pready !== 1'b1) begin
            @(negedge clk_i);
        end
        rdata = apb_o.prdata;
        err   = apb_o.pslverr;
        @(posedge clk_i);
        #1;
        apb_i = '0;
    endtask

    task automatic issue_inst(input inst_t inst);
        logic [xlen-1:0] rdata;
        logic            err;
        apb_xfer(1'b1, addr_issue, inst, rdata, err);
        check_flag("apb_o.pslverr", err, 1'b0);
        record_issue(inst);
        issue_cnt = issue_cnt + 1;
    endtask

    task automatic verify_reg(input int r, input logic [xlen-1:0] exp);
        logic [xlen-1:0] rdata;
        logic            err;
        apb_xfer(1'b0, addr_reg_base + apb_aw'(4 * r), '0, rdata, err);
        check_flag("apb_o.pslverr", err, 1'b0);
        check_word($sformatf("apb_o.prdata r%0d", r), rdata, exp);
    endtask

    // Half of the picks land in r0..r3 for heavy reuse
    function automatic logic [reg_aw-1:0] pick_reg();
        logic [31:0] r;
        r = $random(seed);
        return r[8] ? {2'b00, r[1:0]} : r[7:4];
    endfunction

    function automatic inst_t random_inst();
        inst_t       inst;
        logic [31:0] r;
        r        = $random(seed);
        inst.op  = op_e'({1'b0, r[2:0]});
        inst.imm = r[31:16];
        inst.rd  = pick_reg();
        inst.rs1 = pick_reg();
        inst.rs2 = pick_reg();
        return inst;
    endfunction

    // Back-to-back dependency chain on r5, longer than the ROB
    task automatic issue_burst();
        inst_t inst;
        for (int i = 0; i < n_burst; i++) begin
            inst     = random_inst();
            inst.rd  = 4'd5;
            inst.rs1 = 4'd5;
            if (i % 4 == 0) begin
                inst.op = OP_ADDI;
            end
            issue_inst(inst);
        end
    endtask

    task automatic probe_bad_addresses();
        logic [xlen-1:0] rdata;
        logic            err;
        apb_xfer(1'b1, 12'h004, random_inst(), rdata, err);
        check_flag("apb_o.pslverr", err, 1'b1);
        apb_xfer(1'b1, addr_reg_base, random_inst(), rdata, err);
        check_flag("apb_o.pslverr", err, 1'b1);
        apb_xfer(1'b0, addr_reg_base + 12'h040, '0, rdata, err);
        check_flag("apb_o.pslverr", err, 1'b1);
        check_word("apb_o.prdata", rdata, '0);
        apb_xfer(1'b0, addr_reg_base + 12'h006, '0, rdata, err);
        check_flag("apb_o.pslverr", err, 1'b1);
        check_word("apb_o.prdata", rdata, '0);
        apb_xfer(1'b0, addr_issue, '0, rdata, err);
        check_flag("apb_o.pslverr", err, 1'b1);
        check_word("apb_o.prdata", rdata, '0);
    endtask

    task automatic wait_drain();
        while (commit_cnt != issue_cnt) begin
            @(posedge clk_i);
            #1;
        end
    endtask

    initial begin
        clk_i   = 1'b0;
        rst_n_i = 1'b0;
        apb_i   = '0;
        seed    = 32'ha490_6912;
        clear_model();
        repeat (10) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;

        for (int r = 0; r < num_regs; r++) begin
            verify_reg(r, '0);
        end
        for (int i = 0; i < n_prog; i++) begin
            issue_inst(random_inst());
        end
        issue_burst();
        probe_bad_addresses();
        for (int i = 0; i < n_tail; i++) begin
            issue_inst(random_inst());
        end
        wait_drain();
        for (int r = 0; r < num_regs; r++) begin
            verify_reg(r, model_regs[r]);
        end

        $display("STATUS: PASS");
        $finish;
    end

endmodule
